//--- files.f
design/csr_pkg.sv
design/csr_rmw.sv
design/csr_regs.sv
design/trap_ctrl.sv
design/csr_unit.sv
bench/csr_unit_tb.sv

//--- Bender.yml
package:
  name: csr_unit

sources:
  # Package first, then the blocks, then the top level
  - design/csr_pkg.sv
  - design/csr_rmw.sv
  - design/csr_regs.sv
  - design/trap_ctrl.sv
  - design/csr_unit.sv

  - target: simulation
    files:
      - bench/csr_unit_tb.sv

//--- bench/csr_unit_tb.sv
`default_nettype none

module csr_unit_tb;

    import csr_pkg::*;

    localparam int CLK_PERIOD   = 100;
    localparam int RESET_CYCLES = 3;
    localparam int NUM_RANDOM   = 200;

    typedef enum logic [1:0] {
        K_CSR,
        K_ECALL,
        K_MRET,
        K_IDLE
    } kind_e;

    typedef struct packed {
        kind_e     kind;
        csr_op_t   op;
        csr_addr_t addr;
        word_t     operand;
        word_t     pc;
    } row_t;

    logic      clk;
    logic      rst_n;
    csr_req_t  csr_req;
    logic      ecall;
    logic      mret;
    word_t     pc;
    word_t     rd_data;
    redirect_t redirect;

    row_t      rows[$];
    logic      table_ready;
    int        seed;
    int        word_errors;
    int        redirect_errors;

    word_t     m_mstatus;
    word_t     m_mtvec;
    word_t     m_mscratch;
    word_t     m_mepc;
    word_t     m_mcause;
    redirect_t m_pending; // Redirect expected in the cycle after an ecall or mret

    csr_unit dut0 (
        .clk      (clk),
        .rst_n    (rst_n),
        .csr_req  (csr_req),
        .ecall    (ecall),
        .mret     (mret),
        .pc       (pc),
        .rd_data  (rd_data),
        .redirect (redirect)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // ##########################################################
    // Reference model
    // ##########################################################

    function automatic word_t model_read(input csr_addr_t addr);
        case (addr)
            ADDR_MSTATUS:  return m_mstatus;
            ADDR_MTVEC:    return m_mtvec;
            ADDR_MSCRATCH: return m_mscratch;
            ADDR_MEPC:     return m_mepc;
            ADDR_MCAUSE:   return m_mcause;
            default:       return '0;
        endcase
    endfunction

    task automatic model_write(input csr_addr_t addr, input word_t value);
        case (addr)
            ADDR_MSTATUS:  m_mstatus = 32'h0000_1800 | (value & 32'h0000_0088); // MPP stays 11
            ADDR_MTVEC:    m_mtvec = value & ~32'h3;
            ADDR_MSCRATCH: m_mscratch = value;
            ADDR_MEPC:     m_mepc = value & ~32'h3;
            ADDR_MCAUSE:   m_mcause = value;
            default:       ;
        endcase
    endtask

    // Applies the effect of the clock edge that ends the row's cycle
    task automatic model_step(input row_t r);
        word_t old;
        old = model_read(r.addr);
        m_pending = '0;
        case (r.kind)
            K_CSR: begin
                if (r.op == CSR_OP_RW) begin
                    model_write(r.addr, r.operand);
                end else if (r.op == CSR_OP_RS && r.operand != '0) begin
                    model_write(r.addr, old | r.operand);
                end else if (r.op == CSR_OP_RC && r.operand != '0) begin
                    model_write(r.addr, old & ~r.operand);
                end
            end
            K_ECALL: begin
                m_pending.valid  = 1'b1;
                m_pending.target = m_mtvec;
                m_mepc           = r.pc & ~32'h3;
                m_mcause         = 32'd11;
                m_mstatus[7]     = m_mstatus[3];
                m_mstatus[3]     = 1'b0;
            end
            K_MRET: begin
                m_pending.valid  = 1'b1;
                m_pending.target = m_mepc;
                m_mstatus[3]     = m_mstatus[7];
                m_mstatus[7]     = 1'b1;
            end
            default: ;
        endcase
    endtask

    // ##########################################################
    // Compare tasks
    // ##########################################################

    task automatic check_word(input string name, input word_t exp, input word_t act);
        if (act !== exp) begin
            $display("FAILED %0t %s expected %h actual %h", $time, name, exp, act);
            word_errors = word_errors + 1;
        end
    endtask

    task automatic check_redirect(input redirect_t exp, input redirect_t act);
        if (exp.valid && act.valid !== 1'b1) begin
            $display("At time %0t the redirect after an ecall or mret did not come", $time);
            redirect_errors = redirect_errors + 1;
        end else if (!exp.valid && act.valid !== 1'b0) begin
            $display("At time %0t a redirect came without an ecall or mret before it", $time);
            redirect_errors = redirect_errors + 1;
        end else if (exp.valid && act.target !== exp.target) begin
            $display("FAILED %0t redirect.target expected %h actual %h",
                     $time, exp.target, act.target);
            redirect_errors = redirect_errors + 1;
        end
    endtask

    // ##########################################################
    // Stimulus table
    // ##########################################################

    task automatic add_row(input kind_e kind, input csr_op_t op, input csr_addr_t addr,
                           input word_t operand, input word_t pc_value);
        row_t r;
        r.kind    = kind;
        r.op      = op;
        r.addr    = addr;
        r.operand = operand;
        r.pc      = pc_value;
        rows.push_back(r);
    endtask

    task automatic add_read(input csr_addr_t addr);
        add_row(K_CSR, CSR_OP_RS, addr, '0, '0); // csrrs with zero operand only reads
    endtask

    task automatic build_table();
        csr_addr_t addr;
        csr_op_t   op;
        word_t     operand;
        add_read(ADDR_MSTATUS);
        add_read(ADDR_MTVEC);
        add_read(ADDR_MSCRATCH);
        add_read(ADDR_MEPC);
        add_read(ADDR_MCAUSE);
        add_row(K_CSR, CSR_OP_RW, ADDR_MTVEC, 32'h8000_0103, '0);
        add_read(ADDR_MTVEC);
        add_row(K_CSR, CSR_OP_RW, ADDR_MSTATUS, 32'hffff_ffff, '0);
        add_read(ADDR_MSTATUS);
        add_row(K_CSR, CSR_OP_RC, ADDR_MSTATUS, 32'h0000_0008, '0);
        add_row(K_CSR, CSR_OP_RS, ADDR_MSTATUS, 32'h0000_0008, '0);
        add_row(K_CSR, CSR_OP_RC, ADDR_MSTATUS, 32'h0000_0000, '0);
        add_read(ADDR_MSTATUS);
        add_row(K_CSR, CSR_OP_RW, ADDR_MSCRATCH, 32'hdead_beef, '0);
        add_row(K_CSR, CSR_OP_RS, ADDR_MSCRATCH, 32'h0000_0010, '0);
        add_row(K_CSR, CSR_OP_RC, ADDR_MSCRATCH, 32'h0000_00ff, '0);
        add_read(ADDR_MSCRATCH);
        add_row(K_CSR, CSR_OP_RW, ADDR_MEPC, 32'h0000_2007, '0);
        add_read(ADDR_MEPC);
        add_row(K_CSR, CSR_OP_RW, ADDR_MCAUSE, 32'h0000_0005, '0);
        add_read(ADDR_MCAUSE);
        // Unknown addresses
        add_row(K_CSR, CSR_OP_RW, 12'h7c0, 32'hffff_ffff, '0);
        add_read(12'h7c0);
        add_row(K_CSR, CSR_OP_RC, 12'h301, 32'hffff_ffff, '0);
        add_read(ADDR_MSTATUS);
        add_read(ADDR_MTVEC);
        add_read(ADDR_MSCRATCH);
        add_read(ADDR_MEPC);
        add_read(ADDR_MCAUSE);
        // Trap entry with MIE set and MPIE clear
        add_row(K_CSR, CSR_OP_RC, ADDR_MSTATUS, 32'h0000_0080, '0);
        add_row(K_ECALL, CSR_OP_RW, '0, '0, 32'h0000_1236);
        add_row(K_IDLE, CSR_OP_RW, '0, '0, '0);
        add_read(ADDR_MEPC);
        add_read(ADDR_MCAUSE);
        add_read(ADDR_MSTATUS);
        // Trap return and then another one with MPIE clear
        add_row(K_CSR, CSR_OP_RW, ADDR_MEPC, 32'h0000_4000, '0);
        add_row(K_MRET, CSR_OP_RW, '0, '0, '0);
        add_row(K_IDLE, CSR_OP_RW, '0, '0, '0);
        add_read(ADDR_MSTATUS);
        add_row(K_CSR, CSR_OP_RC, ADDR_MSTATUS, 32'h0000_0088, '0);
        add_row(K_MRET, CSR_OP_RW, '0, '0, '0);
        add_row(K_IDLE, CSR_OP_RW, '0, '0, '0);
        add_read(ADDR_MSTATUS);
        add_row(K_ECALL, CSR_OP_RW, '0, '0, 32'h0003_0009);
        add_row(K_IDLE, CSR_OP_RW, '0, '0, '0);
        add_row(K_MRET, CSR_OP_RW, '0, '0, '0);
        add_row(K_IDLE, CSR_OP_RW, '0, '0, '0);
        add_read(ADDR_MEPC);
        add_read(ADDR_MSTATUS);
        for (int i = 0; i < NUM_RANDOM; i++) begin
            case ($unsigned($random(seed)) % 8)
                0:       addr = ADDR_MSTATUS;
                1:       addr = ADDR_MTVEC;
                2:       addr = ADDR_MSCRATCH;
                3:       addr = ADDR_MEPC;
                4:       addr = ADDR_MCAUSE;
                default: addr = csr_addr_t'($random(seed)); // Mostly unknown CSRs
            endcase
            op      = csr_op_t'(($unsigned($random(seed)) % 3) + 1);
            operand = (($random(seed) & 3) == 0) ? '0 : word_t'($random(seed));
            add_row(K_CSR, op, addr, operand, '0);
        end
        add_row(K_IDLE, CSR_OP_RW, '0, '0, '0);
    endtask

    task automatic apply_row(input row_t r);
        csr_req_t req;
        word_t    exp_rd;
        req.en      = (r.kind == K_CSR);
        req.op      = r.op;
        req.addr    = r.addr;
        req.operand = r.operand;
        exp_rd      = (r.kind == K_CSR) ? model_read(r.addr) : '0;
        @(posedge clk);
        csr_req <= req;
        ecall   <= (r.kind == K_ECALL);
        mret    <= (r.kind == K_MRET);
        pc      <= r.pc;
        @(negedge clk);
        check_word("rd_data", exp_rd, rd_data);
        check_redirect(m_pending, redirect);
        model_step(r);
    endtask

    // ##########################################################
    // Main sequence and watchdog
    // ##########################################################

    initial begin
        seed            = 32'h1bf5_ead9;
        word_errors     = 0;
        redirect_errors = 0;
        table_ready     = 1'b0;
        rst_n           = 1'b0;
        csr_req         = '0;
        ecall           = 1'b0;
        mret            = 1'b0;
        pc              = '0;
        m_mstatus       = 32'h0000_1800;
        m_mtvec         = '0;
        m_mscratch      = '0;
        m_mepc          = '0;
        m_mcause        = '0;
        m_pending       = '0;
        build_table();
        table_ready = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        rst_n <= 1'b1;
        foreach (rows[i]) begin
            apply_row(rows[i]);
        end
        $display("Errors: %0d value, %0d redirect", word_errors, redirect_errors);
        if (word_errors == 0 && redirect_errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

    initial begin
        wait (table_ready);
        #(CLK_PERIOD * (rows.size() + 50));
        $display("Timeout: the test did not finish within %0d cycles", rows.size() + 50);
        $display(">>> FAIL");
        $finish;
    end

endmodule

`default_nettype wire

//--- design/csr_unit.sv
`default_nettype none

module csr_unit (
    input  wire                  clk,
    input  wire                  rst_n,
    input  wire csr_pkg::csr_req_t csr_req,
    input  wire                  ecall,
    input  wire                  mret,
    input  wire csr_pkg::word_t  pc,
    output csr_pkg::word_t       rd_data,
    output csr_pkg::redirect_t   redirect
);

    import csr_pkg::*;

    csr_wr_t   csr_wr;
    trap_upd_t trap_upd;
    word_t     mtvec_q;
    word_t     mepc_q;

    // rd_data doubles as the old value for the read-modify-write
    csr_rmw u_csr_rmw (
        .csr_req   (csr_req),
        .old_value (rd_data),
        .csr_wr    (csr_wr)
    );

    csr_regs u_csr_regs (
        .clk      (clk),
        .rst_n    (rst_n),
        .rd_addr  (csr_req.addr),
        .rd_en    (csr_req.en),
        .rd_data  (rd_data),
        .csr_wr   (csr_wr),
        .trap_upd (trap_upd),
        .mtvec_q  (mtvec_q),
        .mepc_q   (mepc_q)
    );

    trap_ctrl u_trap_ctrl (
        .clk      (clk),
        .rst_n    (rst_n),
        .ecall    (ecall),
        .mret     (mret),
        .csr_en   (csr_req.en),
        .pc       (pc),
        .mtvec_q  (mtvec_q),
        .mepc_q   (mepc_q),
        .trap_upd (trap_upd),
        .redirect (redirect)
    );

endmodule

`default_nettype wire

//--- design/trap_ctrl.sv
`default_nettype none

module trap_ctrl (
    input  wire                  clk,
    input  wire                  rst_n,
    input  wire                  ecall,
    input  wire                  mret,
    input  wire                  csr_en,
    input  wire csr_pkg::word_t  pc,
    input  wire csr_pkg::word_t  mtvec_q,
    input  wire csr_pkg::word_t  mepc_q,
    output csr_pkg::trap_upd_t   trap_upd,
    output csr_pkg::redirect_t   redirect
);

    import csr_pkg::*;

    typedef enum logic [0:0] {
        IDLE,
        REDIRECT
    } trap_state_e;

    trap_state_e state_q;
    trap_state_e state_d;
    word_t       target_q;
    logic        take_trap;
    logic        take_ret;

    // ##########################################################
    // State machine
    // ##########################################################

    always_comb begin
        take_trap = 1'b0;
        take_ret  = 1'b0;
        state_d   = state_q;
        case (state_q)
            IDLE: begin
                take_trap = ecall;
                take_ret  = mret;
                if (ecall || mret) begin
                    state_d = REDIRECT;
                end
            end
            REDIRECT: begin
                state_d = IDLE; // The pulse lasts one cycle
            end
            default: begin
                state_d = IDLE;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // Target is sampled before the trap update lands in the registers
    always_ff @(posedge clk) begin
        if (take_trap) begin
            target_q <= mtvec_q;
        end else if (take_ret) begin
            target_q <= mepc_q;
        end
    end

    // ##########################################################
    // Outputs
    // ##########################################################

    assign trap_upd.save    = take_trap;
    assign trap_upd.restore = take_ret;
    assign trap_upd.epc     = pc;

    assign redirect.valid  = (state_q == REDIRECT);
    assign redirect.target = target_q;

    // ##########################################################
    // Checks
    // ##########################################################

    // The core issues at most one strobe per cycle
    a_strobe_onehot: assert property (
        @(posedge clk) disable iff (!rst_n)
        $onehot0({ecall, mret, csr_en})
    ) else $error("trap_ctrl: more than one strobe in a cycle");

    // Nothing is issued while fetch is being redirected
    a_quiet_redirect: assert property (
        @(posedge clk) disable iff (!rst_n)
        (state_q == REDIRECT) |-> !(ecall || mret || csr_en)
    ) else $error("trap_ctrl: strobe during the redirect cycle");

endmodule

`default_nettype wire

//--- design/csr_regs.sv
`default_nettype none

module csr_regs (
    input  wire                      clk,
    input  wire                      rst_n,
    input  wire csr_pkg::csr_addr_t  rd_addr,
    input  wire                      rd_en,
    output csr_pkg::word_t           rd_data,
    input  wire csr_pkg::csr_wr_t    csr_wr,
    input  wire csr_pkg::trap_upd_t  trap_upd,
    output csr_pkg::word_t           mtvec_q,
    output csr_pkg::word_t           mepc_q
);

    import csr_pkg::*;

    word_t mstatus_q;
    word_t mscratch_q;
    word_t mcause_q;
    word_t rd_value;
    word_t mstatus_wdata;

    // ##########################################################
    // Read port
    // ##########################################################

    always_comb begin
        case (rd_addr)
            ADDR_MSTATUS:  rd_value = mstatus_q;
            ADDR_MTVEC:    rd_value = mtvec_q;
            ADDR_MSCRATCH: rd_value = mscratch_q;
            ADDR_MEPC:     rd_value = mepc_q;
            ADDR_MCAUSE:   rd_value = mcause_q;
            default:       rd_value = '0; // Unimplemented CSRs read as zero
        endcase
    end

    assign rd_data = rd_en ? rd_value : '0;

    // ##########################################################
    // Write port and trap update
    // ##########################################################

    // Only MIE and MPIE come from software and MPP stays at 11
    assign mstatus_wdata = (csr_wr.data & MSTATUS_WMASK) | (MSTATUS_RESET & ~MSTATUS_WMASK);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mstatus_q  <= MSTATUS_RESET;
            mtvec_q    <= '0;
            mscratch_q <= '0;
            mepc_q     <= '0;
            mcause_q   <= '0;
        end else if (trap_upd.save) begin
            mepc_q              <= trap_upd.epc & ALIGN_MASK;
            mcause_q            <= CAUSE_ECALL_M;
            mstatus_q[MPIE_BIT] <= mstatus_q[MIE_BIT]; // Stack the interrupt enable
            mstatus_q[MIE_BIT]  <= 1'b0;
        end else if (trap_upd.restore) begin
            mstatus_q[MIE_BIT]  <= mstatus_q[MPIE_BIT];
            mstatus_q[MPIE_BIT] <= 1'b1;
        end else if (csr_wr.en) begin
            case (csr_wr.addr)
                ADDR_MSTATUS:  mstatus_q  <= mstatus_wdata;
                ADDR_MTVEC:    mtvec_q    <= csr_wr.data & ALIGN_MASK;
                ADDR_MSCRATCH: mscratch_q <= csr_wr.data;
                ADDR_MEPC:     mepc_q     <= csr_wr.data & ALIGN_MASK;
                ADDR_MCAUSE:   mcause_q   <= csr_wr.data;
                default:       ; // Writes to unknown CSRs are dropped
            endcase
        end
    end

    // ##########################################################
    // Checks
    // ##########################################################

    // A CSR write and a trap update never meet in one cycle
    a_wr_trap_excl: assert property (
        @(posedge clk) disable iff (!rst_n)
        !(csr_wr.en && (trap_upd.save || trap_upd.restore))
    ) else $error("csr_regs: CSR write and trap update in the same cycle");

    // Save and restore are never issued together
    a_save_restore_excl: assert property (
        @(posedge clk) disable iff (!rst_n)
        !(trap_upd.save && trap_upd.restore)
    ) else $error("csr_regs: save and restore in the same cycle");

endmodule

`default_nettype wire

//--- design/csr_rmw.sv
`default_nettype none

module csr_rmw (
    input  wire csr_pkg::csr_req_t csr_req,
    input  wire csr_pkg::word_t    old_value,
    output csr_pkg::csr_wr_t       csr_wr
);

    import csr_pkg::*;

    word_t new_value;
    logic  do_write;

    always_comb begin
        new_value = old_value;
        do_write  = 1'b0;
        case (csr_req.op)
            CSR_OP_RW: begin
                new_value = csr_req.operand;
                do_write  = 1'b1;
            end
            CSR_OP_RS: begin
                new_value = old_value | csr_req.operand;
                do_write  = (csr_req.operand != '0); // Zero operand means read only
            end
            CSR_OP_RC: begin
                new_value = old_value & ~csr_req.operand;
                do_write  = (csr_req.operand != '0);
            end
            default: begin
                new_value = old_value;
                do_write  = 1'b0;
            end
        endcase
    end

    assign csr_wr.en   = csr_req.en & do_write;
    assign csr_wr.addr = csr_req.addr;
    assign csr_wr.data = new_value;

    // The decoder only issues the three defined operations
    always_comb begin
        a_op_legal: assert final (!csr_req.en || (csr_req.op inside {CSR_OP_RW, CSR_OP_RS,
                                                                     CSR_OP_RC}))
            else $error("csr_rmw: undefined CSR op %b", csr_req.op);
    end

endmodule

`default_nettype wire

//--- design/csr_pkg.sv
`default_nettype none

package csr_pkg;

    // ##########################################################
    // Widths
    // ##########################################################

    localparam int unsigned XLEN       = 32;
    localparam int unsigned CSR_ADDR_W = 12;
    localparam int unsigned CSR_OP_W   = 2;

    typedef logic [XLEN-1:0]       word_t;
    typedef logic [CSR_ADDR_W-1:0] csr_addr_t;
    typedef logic [CSR_OP_W-1:0]   csr_op_t;

    // ##########################################################
    // Operation codes and CSR addresses
    // ##########################################################

    // Same encoding as funct3[1:0] of the CSR instructions with 2'b00 unused
    localparam csr_op_t CSR_OP_RW = 2'b01;
    localparam csr_op_t CSR_OP_RS = 2'b10;
    localparam csr_op_t CSR_OP_RC = 2'b11;

    localparam csr_addr_t ADDR_MSTATUS  = 12'h300;
    localparam csr_addr_t ADDR_MTVEC    = 12'h305;
    localparam csr_addr_t ADDR_MSCRATCH = 12'h340;
    localparam csr_addr_t ADDR_MEPC     = 12'h341;
    localparam csr_addr_t ADDR_MCAUSE   = 12'h342;

    // ##########################################################
    // Reset values and masks
    // ##########################################################

    localparam int unsigned MIE_BIT  = 3;
    localparam int unsigned MPIE_BIT = 7;

    localparam word_t MSTATUS_RESET = 32'h0000_1800; // MPP is machine mode
    localparam word_t MSTATUS_WMASK = (word_t'(1) << MIE_BIT) | (word_t'(1) << MPIE_BIT);
    localparam word_t ALIGN_MASK    = 32'hffff_fffc; // Direct mode and 4-byte pc
    localparam word_t CAUSE_ECALL_M = 32'd11;

    // ##########################################################
    // Interface structs
    // ##########################################################

    // CSR instruction from the decoder with rs1 or the zero-extended uimm as operand
    typedef struct packed {
        logic      en;
        csr_op_t   op;
        csr_addr_t addr;
        word_t     operand;
    } csr_req_t;

    typedef struct packed {
        logic      en;
        csr_addr_t addr;
        word_t     data;
    } csr_wr_t;

    // Trap entry saves and trap return restores
    typedef struct packed {
        logic  save;
        logic  restore;
        word_t epc;
    } trap_upd_t;

    typedef struct packed {
        logic  valid;
        word_t target;
    } redirect_t;

endpackage

`default_nettype wire
